// File: pqm_config.svh
`ifndef PQM_CONFIG_SVH
`define PQM_CONFIG_SVH

// Number of receive rings handled by one manager
`define PQM_NB_QUEUES 16

// External queue id width; the manager indexes its tables with the top bits
`define PQM_QID_WIDTH 8

// Local table index width, log2 of the queue count
`define PQM_LQ_WIDTH 4

// Ring pointer width, pointers wrap at 2**PQM_PTR_WIDTH
`define PQM_PTR_WIDTH 10

// Packet length in ring slots
`define PQM_SIZE_WIDTH 6

`endif

// File: pqm_pkg.sv
`include "pqm_config.svh"
`default_nettype none

package pqm_pkg;

    // Queue id as seen outside the manager
    typedef logic [`PQM_QID_WIDTH-1:0] queue_id_t;

    // Index into the per-queue tables, taken from the top bits of queue_id_t
    typedef logic [`PQM_LQ_WIDTH-1:0] local_queue_t;

    // Head or tail pointer of a ring
    typedef logic [`PQM_PTR_WIDTH-1:0] ring_ptr_t;

    // Usable ring capacity, one bit wider so a full pointer range fits
    typedef logic [`PQM_PTR_WIDTH:0] rb_size_t;

    // Packet length in ring slots
    typedef logic [`PQM_SIZE_WIDTH-1:0] pkt_size_t;

    // Free-running event counter
    typedef logic [31:0] event_count_t;

endpackage

`default_nettype wire

// File: pqm_meta_if.sv
`timescale 1ns/1ns
`default_nettype none

// One metadata record and its valid/ready handshake between pipeline modules
interface pqm_meta_if;

    logic                   valid;
    logic                   ready;
    pqm_pkg::queue_id_t     queue;
    pqm_pkg::local_queue_t  lqueue;
    pqm_pkg::pkt_size_t     size;
    logic                   head_update;
    pqm_pkg::ring_ptr_t     head;
    pqm_pkg::ring_ptr_t     tail;
    logic                   drop;
    logic                   needs_dsc;

    // The source holds a record steady until valid and ready meet on an edge
    modport source (
        output valid, queue, lqueue, size, head_update,
        output head, tail, drop, needs_dsc,
        input  ready
    );

    modport sink (
        input  valid, queue, lqueue, size, head_update,
        input  head, tail, drop, needs_dsc,
        output ready
    );

endinterface

`default_nettype wire

// File: pqm_decode.sv
`include "pqm_config.svh"
`timescale 1ns/1ns
`default_nettype none

module pqm_decode (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     in_valid,
    output logic                    in_ready,
    input  wire pqm_pkg::queue_id_t in_queue,
    input  wire pqm_pkg::pkt_size_t in_size,
    input  wire                     in_head_update,
    input  wire pqm_pkg::ring_ptr_t in_head,
    pqm_meta_if.source              dec_out
);

    // Slot 0 always holds the oldest record and feeds the output
    pqm_pkg::queue_id_t queue_q [2];
    pqm_pkg::pkt_size_t size_q [2];
    logic               hu_q [2];
    pqm_pkg::ring_ptr_t head_q [2];

    logic [1:0] count_q;
    logic [1:0] count_next;
    logic       push;
    logic       pop;
    logic       wr_idx;

    assign push = in_valid & in_ready;
    assign pop  = dec_out.valid & dec_out.ready;

    // A push lands behind whatever is left after this cycle's pop.
    // With two entries held in_ready is low, so only counts 0 and 1 matter
    assign wr_idx = count_q[0] & ~pop;

    assign count_next = count_q + {1'b0, push} - {1'b0, pop};

    // Ready comes from a register so the input never sees out_ready directly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q  <= 2'd0;
            in_ready <= 1'b0;
        end else begin
            count_q  <= count_next;
            in_ready <= (count_next != 2'd2);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            queue_q[0] <= queue_q[1];
            size_q[0]  <= size_q[1];
            hu_q[0]    <= hu_q[1];
            head_q[0]  <= head_q[1];
        end
        if (push) begin
            queue_q[wr_idx] <= in_queue;
            size_q[wr_idx]  <= in_size;
            hu_q[wr_idx]    <= in_head_update;
            head_q[wr_idx]  <= in_head;
        end
    end

    assign dec_out.valid       = (count_q != 2'd0);
    assign dec_out.queue       = queue_q[0];
    // Low bits of the id pick a sibling manager outside, so index with the top bits
    assign dec_out.lqueue      = queue_q[0][`PQM_QID_WIDTH-1 -: `PQM_LQ_WIDTH];
    assign dec_out.size        = size_q[0];
    assign dec_out.head_update = hu_q[0];
    assign dec_out.head        = head_q[0];
    assign dec_out.tail        = '0;
    assign dec_out.drop        = 1'b0;
    assign dec_out.needs_dsc   = 1'b0;

endmodule

`default_nettype wire

// File: pqm_execute.sv
`include "pqm_config.svh"
`timescale 1ns/1ns
`default_nettype none

module pqm_execute (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire pqm_pkg::rb_size_t  rb_size,
    pqm_meta_if.sink                exe_in,
    pqm_meta_if.source              exe_out,
    output pqm_pkg::event_count_t   full_cnt
);

    pqm_pkg::ring_ptr_t head_tab [`PQM_NB_QUEUES];
    pqm_pkg::ring_ptr_t tail_tab [`PQM_NB_QUEUES];

    // Stage one holds the record and the table values read for it
    logic                  s1_valid;
    pqm_pkg::queue_id_t    s1_queue;
    pqm_pkg::local_queue_t s1_lqueue;
    pqm_pkg::pkt_size_t    s1_size;
    logic                  s1_head_update;
    pqm_pkg::ring_ptr_t    s1_head;
    logic                  s1_drop;
    logic                  s1_needs_dsc;
    pqm_pkg::ring_ptr_t    rd_head;
    pqm_pkg::ring_ptr_t    rd_tail;

    // The most recent table write serves a next record to the same queue
    logic                  wr_valid_q;
    pqm_pkg::local_queue_t wr_lqueue_q;
    pqm_pkg::ring_ptr_t    wr_head_q;
    pqm_pkg::ring_ptr_t    wr_tail_q;

    logic                  s1_adv;
    logic                  s2_adv;
    pqm_pkg::ring_ptr_t    cur_head;
    pqm_pkg::ring_ptr_t    cur_tail;
    pqm_pkg::ring_ptr_t    occupancy;
    pqm_pkg::rb_size_t     fill;
    logic                  overflow;
    logic                  drop;
    pqm_pkg::ring_ptr_t    new_head;
    pqm_pkg::ring_ptr_t    new_tail;

    assign s2_adv       = ~exe_out.valid | exe_out.ready;
    assign s1_adv       = ~s1_valid | s2_adv;
    assign exe_in.ready = s1_adv;

    always_comb begin
        // The write made on the edge that loaded stage one is missing from the read
        if (wr_valid_q && (wr_lqueue_q == s1_lqueue)) begin
            cur_head = wr_head_q;
            cur_tail = wr_tail_q;
        end else begin
            cur_head = rd_head;
            cur_tail = rd_tail;
        end
        occupancy = cur_tail - cur_head;
        fill      = {1'b0, occupancy} + pqm_pkg::rb_size_t'(s1_size);
        overflow  = ~s1_head_update & ~s1_drop & (fill >= rb_size);
        drop      = s1_drop | overflow;
        new_head  = s1_head_update ? s1_head : cur_head;
        if (s1_head_update || drop) begin
            new_tail = cur_tail;
        end else begin
            new_tail = cur_tail + pqm_pkg::ring_ptr_t'(s1_size);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid      <= 1'b0;
            exe_out.valid <= 1'b0;
            wr_valid_q    <= 1'b0;
            full_cnt      <= '0;
            for (int i = 0; i < `PQM_NB_QUEUES; i++) begin
                head_tab[i] <= '0;
                tail_tab[i] <= '0;
            end
        end else begin
            if (s1_adv) begin
                s1_valid <= exe_in.valid;
            end
            if (s2_adv) begin
                exe_out.valid <= s1_valid;
                if (s1_valid) begin
                    head_tab[s1_lqueue] <= new_head;
                    tail_tab[s1_lqueue] <= new_tail;
                    wr_valid_q          <= 1'b1;
                    if (overflow) begin
                        full_cnt <= full_cnt + pqm_pkg::event_count_t'(1);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_adv && exe_in.valid) begin
            s1_queue       <= exe_in.queue;
            s1_lqueue      <= exe_in.lqueue;
            s1_size        <= exe_in.size;
            s1_head_update <= exe_in.head_update;
            s1_head        <= exe_in.head;
            s1_drop        <= exe_in.drop;
            s1_needs_dsc   <= exe_in.needs_dsc;
            rd_head        <= head_tab[exe_in.lqueue];
            rd_tail        <= tail_tab[exe_in.lqueue];
        end
        if (s2_adv && s1_valid) begin
            exe_out.queue       <= s1_queue;
            exe_out.lqueue      <= s1_lqueue;
            exe_out.size        <= s1_size;
            exe_out.head_update <= s1_head_update;
            exe_out.head        <= new_head;
            exe_out.tail        <= new_tail;
            exe_out.drop        <= drop;
            exe_out.needs_dsc   <= s1_needs_dsc & ~drop;
            wr_lqueue_q         <= s1_lqueue;
            wr_head_q           <= new_head;
            wr_tail_q           <= new_tail;
        end
    end

endmodule

`default_nettype wire

// File: pqm_result.sv
`include "pqm_config.svh"
`timescale 1ns/1ns
`default_nettype none

module pqm_result (
    input  wire                     clk,
    input  wire                     rst_n,
    pqm_meta_if.sink                res_in,
    output logic                    out_valid,
    input  wire                     out_ready,
    output pqm_pkg::queue_id_t      out_queue,
    output pqm_pkg::ring_ptr_t      out_head,
    output pqm_pkg::ring_ptr_t      out_tail,
    output logic                    out_drop,
    output logic                    out_needs_dsc,
    output logic                    out_head_update
);

    // A set bit means the queue has a descriptor outstanding
    logic [`PQM_NB_QUEUES-1:0] status_q;

    logic                  s1_valid;
    pqm_pkg::queue_id_t    s1_queue;
    pqm_pkg::local_queue_t s1_lqueue;
    logic                  s1_head_update;
    pqm_pkg::ring_ptr_t    s1_head;
    pqm_pkg::ring_ptr_t    s1_tail;
    logic                  s1_drop;
    logic                  rd_status;

    logic                  wr_valid_q;
    pqm_pkg::local_queue_t wr_lqueue_q;
    logic                  wr_status_q;

    logic                  s1_adv;
    logic                  s2_adv;
    logic                  cur_status;
    logic                  empty_update;
    logic                  dec_drop;
    logic                  dec_dsc;
    logic                  new_status;

    assign s2_adv       = ~out_valid | out_ready;
    assign s1_adv       = ~s1_valid | s2_adv;
    assign res_in.ready = s1_adv;

    always_comb begin
        if (wr_valid_q && (wr_lqueue_q == s1_lqueue)) begin
            cur_status = wr_status_q;
        end else begin
            cur_status = rd_status;
        end
        empty_update = s1_head_update & (s1_head == s1_tail);
        if (s1_head_update) begin
            // Software caught up with an empty ring, so re-arm the queue
            dec_drop   = empty_update;
            dec_dsc    = ~empty_update;
            new_status = ~empty_update;
        end else if (s1_drop) begin
            dec_drop   = 1'b1;
            dec_dsc    = 1'b0;
            new_status = cur_status;
        end else begin
            dec_drop   = 1'b0;
            dec_dsc    = ~cur_status;
            new_status = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            out_valid  <= 1'b0;
            wr_valid_q <= 1'b0;
            status_q   <= '0;
        end else begin
            if (s1_adv) begin
                s1_valid <= res_in.valid;
            end
            if (s2_adv) begin
                out_valid <= s1_valid;
                if (s1_valid) begin
                    status_q[s1_lqueue] <= new_status;
                    wr_valid_q          <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_adv && res_in.valid) begin
            s1_queue       <= res_in.queue;
            s1_lqueue      <= res_in.lqueue;
            s1_head_update <= res_in.head_update;
            s1_head        <= res_in.head;
            s1_tail        <= res_in.tail;
            s1_drop        <= res_in.drop;
            rd_status      <= status_q[res_in.lqueue];
        end
        if (s2_adv && s1_valid) begin
            out_queue       <= s1_queue;
            out_head        <= s1_head;
            out_tail        <= s1_tail;
            out_drop        <= dec_drop;
            out_needs_dsc   <= dec_dsc;
            out_head_update <= s1_head_update;
            wr_lqueue_q     <= s1_lqueue;
            wr_status_q     <= new_status;
        end
    end

endmodule

`default_nettype wire

// File: pkt_queue_manager.sv
`timescale 1ns/1ns
`default_nettype none

module pkt_queue_manager (
    input  wire                         clk,
    input  wire                         rst_n,

    // Incoming metadata records
    input  wire                         in_valid,
    output wire                         in_ready,
    input  wire pqm_pkg::queue_id_t     in_queue,
    input  wire pqm_pkg::pkt_size_t     in_size,
    input  wire                         in_head_update,
    input  wire pqm_pkg::ring_ptr_t     in_head,

    // Records with ring state and descriptor decision
    output wire                         out_valid,
    input  wire                         out_ready,
    output wire pqm_pkg::queue_id_t     out_queue,
    output wire pqm_pkg::ring_ptr_t     out_head,
    output wire pqm_pkg::ring_ptr_t     out_tail,
    output wire                         out_drop,
    output wire                         out_needs_dsc,
    output wire                         out_head_update,

    input  wire pqm_pkg::rb_size_t      rb_size,
    output wire pqm_pkg::event_count_t  full_cnt
);

    pqm_meta_if dec_to_exe ();
    pqm_meta_if exe_to_res ();

    pqm_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_queue       (in_queue),
        .in_size        (in_size),
        .in_head_update (in_head_update),
        .in_head        (in_head),
        .dec_out        (dec_to_exe.source)
    );

    // Pointer tables and overflow drops
    pqm_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .rb_size  (rb_size),
        .exe_in   (dec_to_exe.sink),
        .exe_out  (exe_to_res.source),
        .full_cnt (full_cnt)
    );

    // One outstanding descriptor per queue
    pqm_result u_result (
        .clk             (clk),
        .rst_n           (rst_n),
        .res_in          (exe_to_res.sink),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_queue       (out_queue),
        .out_head        (out_head),
        .out_tail        (out_tail),
        .out_drop        (out_drop),
        .out_needs_dsc   (out_needs_dsc),
        .out_head_update (out_head_update)
    );

endmodule

`default_nettype wire

// File: pqm_properties.sv
`timescale 1ns/1ns
`default_nettype none

module pqm_properties (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         in_ready,
    input  wire                         out_valid,
    input  wire                         out_ready,
    input  wire pqm_pkg::queue_id_t     out_queue,
    input  wire pqm_pkg::ring_ptr_t     out_head,
    input  wire pqm_pkg::ring_ptr_t     out_tail,
    input  wire                         out_drop,
    input  wire                         out_needs_dsc,
    input  wire                         out_head_update,
    input  wire pqm_pkg::event_count_t  full_cnt
);

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid && !in_ready)
        else $error("out_valid or in_ready high while reset is asserted");

    // A record waiting on out_ready must not change until it is taken
    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_queue) && $stable(out_head)
            && $stable(out_tail) && $stable(out_drop) && $stable(out_needs_dsc)
            && $stable(out_head_update))
        else $error("Output record changed while stalled");

    drop_no_dsc: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_drop |-> !out_needs_dsc)
        else $error("Dropped record carries a descriptor");

    cnt_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        full_cnt >= $past(full_cnt))
        else $error("full_cnt decreased");

endmodule

`default_nettype wire

// File: tb_pkt_queue_manager.sv
`include "pqm_config.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_pkt_queue_manager;

    localparam int NUM_RECORDS    = 1500;
    localparam int TIMEOUT_CYCLES = NUM_RECORDS * 8 + 200;

    typedef struct packed {
        pqm_pkg::queue_id_t queue;
        pqm_pkg::ring_ptr_t head;
        pqm_pkg::ring_ptr_t tail;
        logic               drop;
        logic               needs_dsc;
        logic               head_update;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_ready;
    pqm_pkg::queue_id_t    in_queue;
    pqm_pkg::pkt_size_t    in_size;
    logic                  in_head_update;
    pqm_pkg::ring_ptr_t    in_head;
    logic                  out_valid;
    logic                  out_ready;
    pqm_pkg::queue_id_t    out_queue;
    pqm_pkg::ring_ptr_t    out_head;
    pqm_pkg::ring_ptr_t    out_tail;
    logic                  out_drop;
    logic                  out_needs_dsc;
    logic                  out_head_update;
    pqm_pkg::rb_size_t     rb_size;
    pqm_pkg::event_count_t full_cnt;

    // Reference model state, one entry per local queue
    pqm_pkg::ring_ptr_t    m_head [`PQM_NB_QUEUES];
    pqm_pkg::ring_ptr_t    m_tail [`PQM_NB_QUEUES];
    logic                  m_status [`PQM_NB_QUEUES];
    pqm_pkg::event_count_t drop_cnt;
    expect_t               exp_q [$];

    int   errors;
    int   sent;
    int   received;
    int   cycles;
    logic stim_on;
    logic took;

    pkt_queue_manager UUT (.*);

    bind pkt_queue_manager pqm_properties u_props (.*);

    always #50 clk = ~clk;

    task automatic check_ptr(input pqm_pkg::ring_ptr_t got, input pqm_pkg::ring_ptr_t exp,
                             input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_queue(input pqm_pkg::queue_id_t got, input pqm_pkg::queue_id_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: out_queue is %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input pqm_pkg::event_count_t got,
                               input pqm_pkg::event_count_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: full_cnt is %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    // Pick the next record, mostly on three busy queues so hazards are frequent
    task automatic make_record;
        pqm_pkg::local_queue_t lq;
        int pick;
        int occ;
        int off;
        pick = $urandom % 100;
        if (pick < 30) begin
            lq = pqm_pkg::local_queue_t'(2);
        end else if (pick < 60) begin
            lq = pqm_pkg::local_queue_t'(7);
        end else if (pick < 90) begin
            lq = pqm_pkg::local_queue_t'(11);
        end else begin
            lq = pqm_pkg::local_queue_t'($urandom % `PQM_NB_QUEUES);
        end
        in_queue       = {lq, (`PQM_QID_WIDTH-`PQM_LQ_WIDTH)'($urandom)};
        in_head_update = (($urandom % 4) == 0);
        in_size        = pqm_pkg::pkt_size_t'(1 + $urandom % 24);
        in_head        = pqm_pkg::ring_ptr_t'($urandom);
        if (in_head_update) begin
            // Software never moves the head past the tail, and often catches up fully
            occ = int'(pqm_pkg::ring_ptr_t'(m_tail[lq] - m_head[lq]));
            if (($urandom % 2) == 0) begin
                off = occ;
            end else begin
                off = int'($urandom % (occ + 1));
            end
            in_head = m_head[lq] + pqm_pkg::ring_ptr_t'(off);
        end
    endtask

    task automatic apply_model;
        pqm_pkg::local_queue_t lq;
        expect_t e;
        int occ;
        lq            = in_queue[`PQM_QID_WIDTH-1 -: `PQM_LQ_WIDTH];
        e.queue       = in_queue;
        e.head_update = in_head_update;
        if (in_head_update) begin
            m_head[lq]   = in_head;
            e.drop       = (in_head == m_tail[lq]);
            e.needs_dsc  = !e.drop;
            m_status[lq] = !e.drop;
        end else begin
            occ = int'(pqm_pkg::ring_ptr_t'(m_tail[lq] - m_head[lq]));
            if (occ + int'(in_size) >= int'(rb_size)) begin
                e.drop      = 1'b1;
                e.needs_dsc = 1'b0;
                drop_cnt    = drop_cnt + 32'd1;
            end else begin
                m_tail[lq]   = m_tail[lq] + pqm_pkg::ring_ptr_t'(in_size);
                e.drop       = 1'b0;
                e.needs_dsc  = !m_status[lq];
                m_status[lq] = 1'b1;
            end
        end
        e.head = m_head[lq];
        e.tail = m_tail[lq];
        exp_q.push_back(e);
    endtask

    task automatic compare_output;
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("Output record for queue %0d at %0t ns has no matching input record",
                     out_queue, $time);
            errors++;
        end else begin
            e = exp_q.pop_front();
            check_queue(out_queue, e.queue);
            check_ptr(out_head, e.head, "out_head");
            check_ptr(out_tail, e.tail, "out_tail");
            check_flag(out_drop, e.drop, "out_drop");
            check_flag(out_needs_dsc, e.needs_dsc, "out_needs_dsc");
            check_flag(out_head_update, e.head_update, "out_head_update");
        end
        received++;
    endtask

    // Transfers are sampled here, before the edge updates the DUT registers
    always @(posedge clk) begin
        took = 1'b0;
        if (rst_n && in_valid && in_ready) begin
            apply_model();
            took = 1'b1;
        end
        if (rst_n && out_valid && out_ready) begin
            compare_output();
        end
    end

    always @(negedge clk) begin
        if (stim_on) begin
            out_ready = (($urandom % 100) < 70);
            if (!in_valid || took) begin
                if (sent < NUM_RECORDS && ($urandom % 100) < 85) begin
                    make_record();
                    in_valid = 1'b1;
                    sent++;
                end else begin
                    in_valid = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, only %0d of %0d records came out",
                     cycles, received, NUM_RECORDS);
            errors++;
            $display("Run ended with %0d errors over %0d records", errors, received);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h9507));
        clk            = 1'b0;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_queue       = '0;
        in_size        = '0;
        in_head_update = 1'b0;
        in_head        = '0;
        out_ready      = 1'b0;
        rb_size        = pqm_pkg::rb_size_t'(40);
        drop_cnt       = '0;
        errors         = 0;
        sent           = 0;
        received       = 0;
        cycles         = 0;
        stim_on        = 1'b0;
        took           = 1'b0;
        for (int i = 0; i < `PQM_NB_QUEUES; i++) begin
            m_head[i]   = '0;
            m_tail[i]   = '0;
            m_status[i] = 1'b0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        stim_on = 1'b1;
        wait (received == NUM_RECORDS);
        repeat (4) @(posedge clk);
        check_count(full_cnt, drop_cnt);
        if (out_valid) begin
            $display("Output still valid after all %0d records were received", NUM_RECORDS);
            errors++;
        end
        $display("Run ended with %0d errors over %0d records", errors, received);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
pqm_pkg.sv
pqm_meta_if.sv
pqm_decode.sv
pqm_execute.sv
pqm_result.sv
pkt_queue_manager.sv
pqm_properties.sv
tb_pkt_queue_manager.sv

// File: run.sh
#!/bin/sh
# Compile the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_pkt_queue_manager \
    -f list.f -Mdir obj_dir -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    exit 0
fi
echo "Simulation did not report success"
exit 1
